/* Makefile */
# Verilator build and run of the cpu testbench

TOP := tb_cpu

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator from project.f and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f project.f -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir

/* common/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// register and memory word width
`define CPU_DATA_W 64

// memory addresses are word addresses
`define CPU_ADDR_W 64

// general registers, and the same count of flags
`define CPU_NREGS 8
`define CPU_IDX_W ($clog2(`CPU_NREGS))

// instruction fields
`define CPU_IMM_W 32
`define CPU_TARGET_W 48
`define CPU_OPC_W 6

`endif

/* common/cpu_pkg.sv */
`default_nettype none

`include "cpu_defs.svh"

package cpu_pkg;

    // opcode values not listed here execute as no-ops
    typedef enum logic [`CPU_OPC_W-1:0] {
        OP_ADD   = 6'd0,
        OP_SUB   = 6'd1,
        OP_AND   = 6'd2,
        OP_OR    = 6'd3,
        OP_XOR   = 6'd4,
        OP_LDI   = 6'd5,
        OP_SHL   = 6'd6,
        OP_STORE = 6'd7,
        OP_CMPEQ = 6'd8,
        OP_CMPLT = 6'd9,
        OP_FAND  = 6'd10,
        OP_FNOT  = 6'd11,
        OP_JMP   = 6'd12,
        OP_BRF   = 6'd13,
        OP_HALT  = 6'd14
    } opcode_e;

    // one instruction word, read either as an alu op or as a control transfer
    typedef union packed {
        struct packed {
            logic [`CPU_IMM_W-1:0]    imm;
            logic [15:0]              rsvd;
            logic                     half;
            logic [`CPU_IDX_W-1:0]    dest;
            logic [`CPU_IDX_W-1:0]    src_b;
            logic [`CPU_IDX_W-1:0]    src_a;
            opcode_e                  opcode;
        } alu;
        struct packed {
            logic [`CPU_TARGET_W-1:0] target;
            logic [6:0]               rsvd;
            logic [`CPU_IDX_W-1:0]    flag_sel;
            opcode_e                  opcode;
        } xfer;
    } instr_t;

    typedef enum logic [2:0] {
        FETCH,
        FETCH_DROP,
        EXECUTE,
        STORE,
        STORE_DROP,
        HALTED
    } seq_state_e;

endpackage

`default_nettype wire

/* hw/cpu_alu.sv */
`default_nettype none

`include "cpu_defs.svh"

module cpu_alu (
    input  wire cpu_pkg::instr_t         instr,
    input  wire [`CPU_DATA_W-1:0]        a_val,
    input  wire [`CPU_DATA_W-1:0]        b_val,
    input  wire                          fa_val,
    input  wire                          fb_val,
    input  wire [`CPU_ADDR_W-1:0]        pc,
    output logic [`CPU_DATA_W-1:0]       result,
    output logic                         flag_result,
    output logic                         take_branch,
    output logic [`CPU_ADDR_W-1:0]       target
);

    import cpu_pkg::*;

    localparam int SHAMT_W = $clog2(`CPU_DATA_W);
    localparam int KEEP_W  = `CPU_DATA_W - `CPU_IMM_W;

    opcode_e                    opcode;
    logic [`CPU_IMM_W-1:0]      imm;
    logic [SHAMT_W-1:0]         shamt;
    logic [`CPU_ADDR_W-1:0]     jump_addr;

    assign opcode = instr.alu.opcode;
    assign imm    = instr.alu.imm;
    assign shamt  = b_val[SHAMT_W-1:0];

    // transfer target is a word address, zero extended
    assign jump_addr = {{(`CPU_ADDR_W - `CPU_TARGET_W){1'b0}}, instr.xfer.target};

    always_comb
    begin
        result = '0;
        case (opcode)
            OP_ADD:   result = a_val + b_val;
            OP_SUB:   result = a_val - b_val;
            OP_AND:   result = a_val & b_val;
            OP_OR:    result = a_val | b_val;
            OP_XOR:   result = a_val ^ b_val;
            OP_SHL:   result = a_val << shamt;
            OP_LDI:
            begin
                // half set loads the upper word, keeping the lower one
                if (instr.alu.half)
                    result = {imm, a_val[KEEP_W-1:0]};
                else
                    result = {a_val[`CPU_DATA_W-1:`CPU_IMM_W], imm};
            end
            // store data
            OP_STORE: result = a_val;
            default:  result = '0;
        endcase
    end

    always_comb
    begin
        case (opcode)
            OP_CMPEQ: flag_result = (a_val == b_val);
            OP_CMPLT: flag_result = (a_val < b_val);
            OP_FAND:  flag_result = fa_val & fb_val;
            OP_FNOT:  flag_result = ~fa_val;
            default:  flag_result = 1'b0;
        endcase
    end

    assign take_branch = (opcode == OP_JMP) || ((opcode == OP_BRF) && fa_val);

    // next pc, either the transfer target or the following word
    assign target = take_branch ? jump_addr : pc + `CPU_ADDR_W'(1);

endmodule

`default_nettype wire

/* hw/cpu_sequencer.sv */
`default_nettype none

`include "cpu_defs.svh"

module cpu_sequencer (
    input  wire                          clock,
    input  wire                          arst_n,
    output logic                         mem_req,
    output logic                         mem_we,
    output logic [`CPU_ADDR_W-1:0]       mem_addr,
    output logic [`CPU_DATA_W-1:0]       mem_wdata,
    input  wire [`CPU_DATA_W-1:0]        mem_rdata,
    input  wire                          mem_ack,
    output cpu_pkg::instr_t              instr,
    output logic [`CPU_ADDR_W-1:0]       pc,
    input  wire [`CPU_DATA_W-1:0]        result,
    input  wire                          flag_result,
    input  wire                          take_branch,
    input  wire [`CPU_ADDR_W-1:0]        target,
    output logic                         r_we,
    output logic                         f_we,
    output logic                         halted
);

    import cpu_pkg::*;

    seq_state_e state;
    logic       reg_op;
    logic       flag_op;
    logic       req_start;
    logic       req_done;

    // a new request waits until the previous ack has dropped
    assign req_start = !mem_req && !mem_ack;
    assign req_done  = mem_req && mem_ack;

    always_comb
    begin
        reg_op  = 1'b0;
        flag_op = 1'b0;
        case (instr.alu.opcode)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_LDI, OP_SHL:
                reg_op = 1'b1;
            OP_CMPEQ, OP_CMPLT, OP_FAND, OP_FNOT:
                flag_op = 1'b1;
            default:
            begin
                reg_op  = 1'b0;
                flag_op = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state   <= FETCH;
            mem_req <= 1'b0;
            pc      <= '0;
        end
        else
        begin
            case (state)
                FETCH:
                begin
                    if (req_done)
                    begin
                        mem_req <= 1'b0;
                        state   <= FETCH_DROP;
                    end
                    else if (req_start)
                        mem_req <= 1'b1;
                end
                FETCH_DROP:
                    if (!mem_ack)
                        state <= EXECUTE;
                EXECUTE:
                begin
                    pc <= target;
                    if (instr.alu.opcode == OP_HALT)
                        state <= HALTED;
                    else if (instr.alu.opcode == OP_STORE)
                        state <= STORE;
                    else
                        state <= FETCH;
                end
                STORE:
                begin
                    if (req_done)
                    begin
                        mem_req <= 1'b0;
                        state   <= STORE_DROP;
                    end
                    else if (req_start)
                        mem_req <= 1'b1;
                end
                STORE_DROP:
                    if (!mem_ack)
                        state <= FETCH;
                HALTED:
                    state <= HALTED;
                default:
                    state <= FETCH;
            endcase
        end
    end

    // instruction register loads when the fetch is acknowledged
    always_ff @(posedge clock)
    begin
        if (state == FETCH && req_done)
            instr <= mem_rdata;
    end

    always_comb
    begin
        if (state == STORE || state == STORE_DROP)
            mem_addr = {{(`CPU_ADDR_W - `CPU_IMM_W){1'b0}}, instr.alu.imm};
        else
            mem_addr = pc;
    end

    // register file does not change during a store, so the store data holds
    assign mem_wdata = result;
    assign mem_we    = (state == STORE);
    assign r_we      = (state == EXECUTE) && reg_op;
    assign f_we      = (state == EXECUTE) && flag_op;
    assign halted    = (state == HALTED);

    a_req_after_ack_low: assert property (
        @(posedge clock) disable iff (!arst_n)
        (!mem_req && mem_ack) |=> !mem_req
    ) else $error("mem_req raised while mem_ack high");

    a_addr_stable: assert property (
        @(posedge clock) disable iff (!arst_n)
        (mem_req && !mem_ack) |=> $stable(mem_addr)
    ) else $error("mem_addr changed during a request");

endmodule

`default_nettype wire

/* hw/cpu_top.sv */
`default_nettype none

`include "cpu_defs.svh"

module cpu_top (
    input  wire                          clock,
    input  wire                          arst_n,
    output logic                         mem_req,
    output logic                         mem_we,
    output logic [`CPU_ADDR_W-1:0]       mem_addr,
    output logic [`CPU_DATA_W-1:0]       mem_wdata,
    input  wire [`CPU_DATA_W-1:0]        mem_rdata,
    input  wire                          mem_ack,
    output logic                         halted
);

    import cpu_pkg::*;

    instr_t                 instr;
    logic [`CPU_ADDR_W-1:0] pc;
    logic [`CPU_DATA_W-1:0] result;
    logic                   flag_result;
    logic                   take_branch;
    logic [`CPU_ADDR_W-1:0] target;
    logic                   r_we;
    logic                   f_we;
    logic [`CPU_DATA_W-1:0] ra_data;
    logic [`CPU_DATA_W-1:0] rb_data;
    logic                   fa_data;
    logic                   fb_data;

    cpu_sequencer sequencer_inst (
        .clock       (clock),
        .arst_n      (arst_n),
        .mem_req     (mem_req),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_rdata   (mem_rdata),
        .mem_ack     (mem_ack),
        .instr       (instr),
        .pc          (pc),
        .result      (result),
        .flag_result (flag_result),
        .take_branch (take_branch),
        .target      (target),
        .r_we        (r_we),
        .f_we        (f_we),
        .halted      (halted)
    );

    cpu_alu alu_inst (
        .instr       (instr),
        .a_val       (ra_data),
        .b_val       (rb_data),
        .fa_val      (fa_data),
        .fb_val      (fb_data),
        .pc          (pc),
        .result      (result),
        .flag_result (flag_result),
        .take_branch (take_branch),
        .target      (target)
    );

    // flag_sel and src_a share bits 8..6
    reg_file reg_file_inst (
        .clock   (clock),
        .arst_n  (arst_n),
        .ra_idx  (instr.alu.src_a),
        .rb_idx  (instr.alu.src_b),
        .ra_data (ra_data),
        .rb_data (rb_data),
        .fa_idx  (instr.xfer.flag_sel),
        .fb_idx  (instr.alu.src_b),
        .fa_data (fa_data),
        .fb_data (fb_data),
        .r_we    (r_we),
        .r_widx  (instr.alu.dest),
        .r_wdata (result),
        .f_we    (f_we),
        .f_widx  (instr.alu.dest),
        .f_wdata (flag_result)
    );

endmodule

`default_nettype wire

/* hw/reg_file.sv */
`default_nettype none

`include "cpu_defs.svh"

module reg_file (
    input  wire                          clock,
    input  wire                          arst_n,
    input  wire [`CPU_IDX_W-1:0]         ra_idx,
    input  wire [`CPU_IDX_W-1:0]         rb_idx,
    output logic [`CPU_DATA_W-1:0]       ra_data,
    output logic [`CPU_DATA_W-1:0]       rb_data,
    input  wire [`CPU_IDX_W-1:0]         fa_idx,
    input  wire [`CPU_IDX_W-1:0]         fb_idx,
    output logic                         fa_data,
    output logic                         fb_data,
    input  wire                          r_we,
    input  wire [`CPU_IDX_W-1:0]         r_widx,
    input  wire [`CPU_DATA_W-1:0]        r_wdata,
    input  wire                          f_we,
    input  wire [`CPU_IDX_W-1:0]         f_widx,
    input  wire                          f_wdata
);

    logic [`CPU_DATA_W-1:0] regs [`CPU_NREGS];
    logic [`CPU_NREGS-1:0]  flags;

    // asynchronous read ports
    assign ra_data = regs[ra_idx];
    assign rb_data = regs[rb_idx];
    assign fa_data = flags[fa_idx];
    assign fb_data = flags[fb_idx];

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < `CPU_NREGS; i++)
                regs[i] <= '0;
        end
        else if (r_we)
            regs[r_widx] <= r_wdata;
    end

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
            flags <= '0;
        else if (f_we)
            flags[f_widx] <= f_wdata;
    end

    // an instruction writes either a register or a flag, never both
    a_single_write: assert property (
        @(posedge clock) disable iff (!arst_n)
        !(r_we && f_we)
    ) else $error("register and flag written in the same cycle");

endmodule

`default_nettype wire

/* project.f */
+incdir+common
common/cpu_pkg.sv
hw/reg_file.sv
hw/cpu_alu.sv
hw/cpu_sequencer.sv
hw/cpu_top.sv
verif/tb_cpu.sv

/* verif/tb_cpu.sv */
`default_nettype none

`include "cpu_defs.svh"

module tb_cpu;

    timeunit 1ns;
    timeprecision 1ps;

    import cpu_pkg::*;

    localparam int RESET_TIMEOUT = 20;
    localparam int REQ_TIMEOUT   = 40;
    localparam int ACK_TIMEOUT   = 40;
    localparam int HALT_TIMEOUT  = 6000;
    localparam int QUIET_CYCLES  = 50;

    logic                   clock = 1'b0;
    logic                   arst_n;
    logic                   mem_req;
    logic                   mem_we;
    logic [`CPU_ADDR_W-1:0] mem_addr;
    logic [`CPU_DATA_W-1:0] mem_wdata;
    logic [`CPU_DATA_W-1:0] mem_rdata;
    logic                   mem_ack;
    logic                   halted;

    logic [`CPU_DATA_W-1:0] mem [256];
    int                     seed;
    int                     wp;
    int                     wait_cycles;
    int                     reset_cycles;
    logic [`CPU_DATA_W-1:0] rm [`CPU_NREGS];
    logic [`CPU_NREGS-1:0]  fm;

    // expected stores in program order
    logic [`CPU_ADDR_W-1:0] exp_addr_q [$];
    logic [`CPU_DATA_W-1:0] exp_data_q [$];
    string                  exp_name_q [$];
    int                     store_idx;

    logic                   prev_req;
    logic [`CPU_ADDR_W-1:0] prev_addr;
    logic                   prev_we;
    logic                   seen_fetch;

    cpu_top cpu_top_inst (
        .clock     (clock),
        .arst_n    (arst_n),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_ack   (mem_ack),
        .halted    (halted)
    );

    initial
    begin
        forever #20 clock = ~clock;
    end

    task automatic abort_run();
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual)
        begin
            $display("error %s expected %h actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    function automatic logic [63:0] ref_result(input opcode_e op, input logic [63:0] a,
                                               input logic [63:0] b);
        case (op)
            OP_ADD:   ref_result = a + b;
            OP_SUB:   ref_result = a - b;
            OP_AND:   ref_result = a & b;
            OP_OR:    ref_result = a | b;
            OP_XOR:   ref_result = a ^ b;
            OP_SHL:   ref_result = a << b[5:0];
            OP_CMPEQ: ref_result = {63'h0, a == b};
            OP_CMPLT: ref_result = {63'h0, a < b};
            OP_FAND:  ref_result = {63'h0, a[0] & b[0]};
            OP_FNOT:  ref_result = {63'h0, ~a[0]};
            default:  ref_result = 64'h0;
        endcase
    endfunction

    function automatic logic [63:0] enc_alu(input opcode_e op, input int a, input int b,
                                            input int d, input int half,
                                            input logic [31:0] imm);
        enc_alu = {imm, 16'h0, half[0], d[2:0], b[2:0], a[2:0], op};
    endfunction

    function automatic logic [63:0] enc_xfer(input opcode_e op, input int f, input int target);
        enc_xfer = {16'h0, target, 7'h0, f[2:0], op};
    endfunction

    task automatic emit(input logic [63:0] word);
        mem[wp] = word;
        wp++;
    endtask

    task automatic push_store(input int addr, input logic [63:0] data, input string name);
        exp_addr_q.push_back(64'(addr));
        exp_data_q.push_back(data);
        exp_name_q.push_back(name);
    endtask

    task automatic ldi(input int d, input int half, input logic [31:0] imm);
        emit(enc_alu(OP_LDI, d, 0, d, half, imm));
        if (half != 0)
            rm[d] = {imm, rm[d][31:0]};
        else
            rm[d] = {rm[d][63:32], imm};
    endtask

    task automatic load_const(input int d, input logic [63:0] value, input int high_first);
        if (high_first != 0)
        begin
            ldi(d, 1, value[63:32]);
            ldi(d, 0, value[31:0]);
        end
        else
        begin
            ldi(d, 0, value[31:0]);
            ldi(d, 1, value[63:32]);
        end
    endtask

    task automatic store_reg(input int r, input int addr, input string name);
        emit(enc_alu(OP_STORE, r, 0, 0, 0, addr));
        push_store(addr, rm[r], name);
    endtask

    // r4 = r1 op r2 and then stored
    task automatic alu_store(input opcode_e op, input int addr, input string name);
        emit(enc_alu(op, 1, 2, 4, 0, 0));
        rm[4] = ref_result(op, rm[1], rm[2]);
        store_reg(4, addr, name);
    endtask

    task automatic flag_set(input opcode_e op, input int d, input int a, input int b);
        logic [63:0] r;
        emit(enc_alu(op, a, b, d, 0, 0));
        if (op == OP_CMPEQ || op == OP_CMPLT)
            r = ref_result(op, rm[a], rm[b]);
        else
            r = ref_result(op, {63'h0, fm[a]}, {63'h0, fm[b]});
        fm[d] = r[0];
    endtask

    // flag clear stores r1 to addr_clear, flag set jumps to a store of r2 to addr_set
    task automatic branch_on(input int f, input int addr_clear, input int addr_set,
                             input string name);
        int p;
        p = wp;
        emit(enc_xfer(OP_BRF, f, p + 3));
        emit(enc_alu(OP_STORE, 1, 0, 0, 0, addr_clear));
        emit(enc_xfer(OP_JMP, 0, p + 4));
        emit(enc_alu(OP_STORE, 2, 0, 0, 0, addr_set));
        if (fm[f])
            push_store(addr_set, rm[2], name);
        else
            push_store(addr_clear, rm[1], name);
    endtask

    task automatic load_program();
        logic [63:0] a_val;
        logic [63:0] b_val;
        int          p;
        // unused words decode as no-ops
        for (int i = 0; i < 256; i++)
            mem[i] = {{7{i[7:0]}}, 8'hff};
        for (int i = 0; i < `CPU_NREGS; i++)
            rm[i] = 64'h0;
        fm = '0;
        wp = 0;
        a_val[63:32] = $random(seed);
        a_val[31:0]  = $random(seed);
        b_val[63:32] = $random(seed);
        b_val[31:0]  = $random(seed);
        load_const(1, a_val, 0);
        load_const(2, b_val, 1);
        load_const(3, a_val, 0);
        store_reg(1, 200, "LDI low then high");
        store_reg(2, 201, "LDI high then low");
        alu_store(OP_ADD, 202, "ADD");
        alu_store(OP_SUB, 203, "SUB");
        alu_store(OP_AND, 204, "AND");
        alu_store(OP_OR, 205, "OR");
        alu_store(OP_XOR, 206, "XOR");
        alu_store(OP_SHL, 207, "SHL");
        flag_set(OP_CMPEQ, 1, 1, 3);
        flag_set(OP_CMPEQ, 2, 1, 2);
        flag_set(OP_CMPLT, 3, 1, 2);
        flag_set(OP_CMPLT, 6, 2, 1);
        flag_set(OP_FAND, 4, 1, 3);
        flag_set(OP_FNOT, 5, 2, 0);
        branch_on(1, 210, 211, "BRF on CMPEQ equal");
        branch_on(2, 212, 213, "BRF on CMPEQ unequal");
        branch_on(3, 214, 215, "BRF on CMPLT a b");
        branch_on(6, 216, 217, "BRF on CMPLT b a");
        branch_on(4, 218, 219, "BRF on FAND");
        branch_on(5, 220, 221, "BRF on FNOT");
        // the store at 250 lies inside the jump and must never appear
        p = wp;
        emit(enc_xfer(OP_JMP, 0, p + 2));
        emit(enc_alu(OP_STORE, 1, 0, 0, 0, 250));
        store_reg(4, 251, "store after JMP");
        emit(enc_alu(OP_HALT, 0, 0, 0, 0, 0));
    endtask

    task automatic compare_store();
        if (store_idx >= exp_addr_q.size())
        begin
            $display("unexpected store to address %0d", mem_addr);
            abort_run();
        end
        else
        begin
            check({exp_name_q[store_idx], " address"}, exp_addr_q[store_idx], mem_addr);
            check({exp_name_q[store_idx], " data"}, exp_data_q[store_idx], mem_wdata);
            store_idx++;
        end
    endtask

    // serves one request with a random ack delay and ack hold
    task automatic serve_request();
        int         waited;
        int         delay;
        logic [7:0] idx;
        waited = 0;
        while (!mem_req && !halted)
        begin
            @(negedge clock);
            waited++;
            if (waited > REQ_TIMEOUT)
            begin
                $display("timeout: no memory request from the core");
                abort_run();
            end
        end
        if (mem_req)
        begin
            delay = $unsigned($random(seed)) % 6;
            repeat (delay) @(negedge clock);
            idx = mem_addr[7:0];
            if (!mem_we)
                mem_rdata <= mem[idx];
            mem_ack <= 1'b1;
            waited = 0;
            while (mem_req)
            begin
                @(negedge clock);
                waited++;
                if (waited > ACK_TIMEOUT)
                begin
                    $display("timeout: core kept mem_req high after mem_ack");
                    abort_run();
                end
            end
            delay = $unsigned($random(seed)) % 6;
            repeat (delay) @(negedge clock);
            mem_ack <= 1'b0;
        end
    endtask

    initial
    begin
        mem_ack      <= 1'b0;
        mem_rdata    <= '0;
        reset_cycles = 0;
        while (arst_n !== 1'b1)
        begin
            @(negedge clock);
            reset_cycles++;
            if (reset_cycles > RESET_TIMEOUT)
            begin
                $display("timeout: reset was never released");
                abort_run();
            end
        end
        while (!halted)
            serve_request();
    end

    // handshake rules and store contents are checked between rising edges
    always @(negedge clock)
    begin
        if (arst_n)
        begin
            if (mem_req && !prev_req)
            begin
                check("mem_req rose while mem_ack high", 64'h0, 64'(mem_ack));
                if (!seen_fetch)
                begin
                    check("first fetch address", 64'h0, mem_addr);
                    check("first fetch is a read", 64'h0, 64'(mem_we));
                    seen_fetch = 1'b1;
                end
                if (mem_we)
                    compare_store();
            end
            else if (mem_req && prev_req)
            begin
                check("mem_addr stable during request", prev_addr, mem_addr);
                check("mem_we stable during request", 64'(prev_we), 64'(mem_we));
            end
        end
        prev_req  = mem_req;
        prev_addr = mem_addr;
        prev_we   = mem_we;
    end

    initial
    begin
        arst_n     <= 1'b0;
        seed       = 5495;
        store_idx  = 0;
        prev_req   = 1'b0;
        prev_addr  = '0;
        prev_we    = 1'b0;
        seen_fetch = 1'b0;
        load_program();
        repeat (4)
        begin
            @(negedge clock);
            check("mem_req in reset", 64'h0, 64'(mem_req));
            check("mem_we in reset", 64'h0, 64'(mem_we));
            check("halted in reset", 64'h0, 64'(halted));
        end
        arst_n <= 1'b1;
        wait_cycles = 0;
        while (!halted)
        begin
            @(negedge clock);
            wait_cycles++;
            if (wait_cycles > HALT_TIMEOUT)
            begin
                $display("timeout: core did not reach HALT");
                abort_run();
            end
        end
        repeat (QUIET_CYCLES)
        begin
            @(negedge clock);
            check("mem_req after halt", 64'h0, 64'(mem_req));
            check("halted stays high", 64'h1, 64'(halted));
        end
        check("stores seen", 64'(exp_addr_q.size()), 64'(store_idx));
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire
